// File: rv_core_pkg.sv
package rv_core_pkg;

  // machine word
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // major opcodes of the kept subset
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_environ = 7'b1110011;

  // alu function codes
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // selects sub and sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [3:0] {
    alu_none,
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_imm
  } alu_op_e;

  // register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fields_t;

  // immediate layout that also carries the lui bits
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } insn_u;

endpackage

// File: fetch_decode.sv
`timescale 1ns/100ps

module fetch_decode
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic      clk,
  input  logic      rst,
  output word_t     imem_addr,
  input  insn_u     imem_insn,
  output reg_addr_t rf_rs1,
  output reg_addr_t rf_rs2,
  input  word_t     rf_rs1_data,
  input  word_t     rf_rs2_data,
  output logic      d_valid,
  output word_t     d_pc,
  output insn_u     d_insn,
  output alu_op_e   d_op,
  output reg_addr_t d_rd,
  output reg_addr_t d_rs1,
  output reg_addr_t d_rs2,
  output word_t     d_rs1_data,
  output word_t     d_rs2_data,
  output word_t     d_imm,
  output logic      d_use_imm,
  output logic      d_ecall
);

  word_t pc;
  word_t imm_i;
  word_t imm_u;
  logic  funct7_zero;
  logic  funct7_is_alt;

  // the pc just walks forward with no stalls or redirects
  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= RESET_PC;
      d_valid <= 1'b0;
    end else begin
      pc      <= pc + 32'd4;
      d_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    d_pc   <= pc;
    d_insn <= imem_insn;
  end

  assign imem_addr = pc;

  // immediates from the i view of the word
  assign imm_i = {{(xlen - 12){d_insn.i_fields.imm[11]}}, d_insn.i_fields.imm};
  assign imm_u = {d_insn.i_fields.imm, d_insn.i_fields.rs1, d_insn.i_fields.funct3, 12'b0};

  assign funct7_zero   = d_insn.r_fields.funct7 == 7'b0;
  assign funct7_is_alt = d_insn.r_fields.funct7 == funct7_alt;

  always_comb begin
    d_op      = alu_none;
    d_use_imm = 1'b0;
    d_imm     = imm_i;
    d_rs1     = d_insn.r_fields.rs1;
    d_rs2     = '0;
    case (d_insn.r_fields.opcode)
      op_reg_imm: begin
        d_use_imm = 1'b1;
        case (d_insn.i_fields.funct3)
          f3_add_sub: d_op = alu_add;
          f3_slt:     d_op = alu_slt;
          f3_sltu:    d_op = alu_sltu;
          f3_xor:     d_op = alu_xor;
          f3_or:      d_op = alu_or;
          f3_and:     d_op = alu_and;
          // shifts keep funct7 in the upper immediate bits
          f3_sll:     d_op = funct7_zero ? alu_sll : alu_none;
          f3_srl_sra: d_op = funct7_zero ? alu_srl : (funct7_is_alt ? alu_sra : alu_none);
          default:    d_op = alu_none;
        endcase
      end
      op_reg_reg: begin
        d_rs2 = d_insn.r_fields.rs2;
        if (funct7_zero) begin
          case (d_insn.r_fields.funct3)
            f3_add_sub: d_op = alu_add;
            f3_sll:     d_op = alu_sll;
            f3_slt:     d_op = alu_slt;
            f3_sltu:    d_op = alu_sltu;
            f3_xor:     d_op = alu_xor;
            f3_srl_sra: d_op = alu_srl;
            f3_or:      d_op = alu_or;
            default:    d_op = alu_and;
          endcase
        end else if (funct7_is_alt) begin
          if (d_insn.r_fields.funct3 == f3_add_sub) begin
            d_op = alu_sub;
          end else if (d_insn.r_fields.funct3 == f3_srl_sra) begin
            d_op = alu_sra;
          end
        end
      end
      op_lui: begin
        d_op      = alu_pass_imm;
        d_use_imm = 1'b1;
        d_imm     = imm_u;
        d_rs1     = '0;
      end
      default: begin
        d_op = alu_none;
      end
    endcase
  end

  // ecall is the one environment word with every other field zero
  assign d_ecall = d_insn.r_fields.opcode == op_environ && d_insn[31:7] == 25'b0;

  assign d_rd       = d_insn.r_fields.rd;
  assign rf_rs1     = d_rs1;
  assign rf_rs2     = d_rs2;
  assign d_rs1_data = rf_rs1_data;
  assign d_rs2_data = rf_rs2_data;

endmodule

// File: reg_file.sv
`timescale 1ns/100ps

module reg_file
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      we,
  input  reg_addr_t rd,
  input  word_t     rd_data
);

  word_t regs [32];

  // entry 0 is cleared by reset and has no write path
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < 32; i++) begin
        if (we && rd == reg_addr_t'(i)) begin
          regs[i] <= rd_data;
        end
      end
    end
  end

  // write-through so decode sees this cycle's writeback
  assign rs1_data = (we && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (we && rd == rs2) ? rd_data : regs[rs2];

endmodule

// File: execute_writeback.sv
`timescale 1ns/100ps

module execute_writeback
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      d_valid,
  input  word_t     d_pc,
  input  insn_u     d_insn,
  input  alu_op_e   d_op,
  input  reg_addr_t d_rd,
  input  reg_addr_t d_rs1,
  input  reg_addr_t d_rs2,
  input  word_t     d_rs1_data,
  input  word_t     d_rs2_data,
  input  word_t     d_imm,
  input  logic      d_use_imm,
  input  logic      d_ecall,
  output logic      wb_we,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      trace_valid,
  output word_t     trace_pc,
  output insn_u     trace_insn,
  output logic      trace_we,
  output reg_addr_t trace_rd,
  output word_t     trace_data,
  output logic      halt
);

  // execute stage register
  logic      e_valid;
  word_t     e_pc;
  insn_u     e_insn;
  alu_op_e   e_op;
  reg_addr_t e_rd;
  reg_addr_t e_rs1;
  reg_addr_t e_rs2;
  word_t     e_rs1_data;
  word_t     e_rs2_data;
  word_t     e_imm;
  logic      e_use_imm;
  logic      e_ecall;

  // writeback stage register
  logic      w_valid;
  logic      w_we;
  logic      w_halt;
  word_t     w_pc;
  insn_u     w_insn;
  reg_addr_t w_rd;
  word_t     w_data;

  word_t     op_a;
  word_t     op_b_reg;
  word_t     op_b;
  word_t     result;
  logic      e_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      e_valid <= 1'b0;
    end else begin
      e_valid <= d_valid;
    end
  end

  always_ff @(posedge clk) begin
    e_pc       <= d_pc;
    e_insn     <= d_insn;
    e_op       <= d_op;
    e_rd       <= d_rd;
    e_rs1      <= d_rs1;
    e_rs2      <= d_rs2;
    e_rs1_data <= d_rs1_data;
    e_rs2_data <= d_rs2_data;
    e_imm      <= d_imm;
    e_use_imm  <= d_use_imm;
    e_ecall    <= d_ecall;
  end

  // older instruction sitting in writeback wins over the captured operand
  assign op_a     = (w_we && w_rd == e_rs1) ? w_data : e_rs1_data;
  assign op_b_reg = (w_we && w_rd == e_rs2) ? w_data : e_rs2_data;
  assign op_b     = e_use_imm ? e_imm : op_b_reg;

  always_comb begin
    case (e_op)
      alu_add:      result = op_a + op_b;
      alu_sub:      result = op_a - op_b;
      alu_sll:      result = op_a << op_b[4:0];
      alu_slt:      result = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu:     result = word_t'(op_a < op_b);
      alu_xor:      result = op_a ^ op_b;
      alu_srl:      result = op_a >> op_b[4:0];
      alu_sra:      result = word_t'($signed(op_a) >>> op_b[4:0]);
      alu_or:       result = op_a | op_b;
      alu_and:      result = op_a & op_b;
      alu_pass_imm: result = e_imm;
      default:      result = '0;
    endcase
  end

  // x0 writes and unknown words retire without a write
  assign e_we = e_valid && e_op != alu_none && e_rd != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_valid <= 1'b0;
      w_we    <= 1'b0;
      w_halt  <= 1'b0;
    end else begin
      w_valid <= e_valid;
      w_we    <= e_we;
      w_halt  <= e_valid && e_ecall;
    end
  end

  always_ff @(posedge clk) begin
    w_pc   <= e_pc;
    w_insn <= e_insn;
    w_rd   <= e_rd;
    w_data <= result;
  end

  assign wb_we       = w_we;
  assign wb_rd       = w_rd;
  assign wb_data     = w_data;

  assign trace_valid = w_valid;
  assign trace_pc    = w_pc;
  assign trace_insn  = w_insn;
  assign trace_we    = w_we;
  assign trace_rd    = w_rd;
  assign trace_data  = w_data;
  assign halt        = w_halt;

endmodule

// File: rv_core.sv
`timescale 1ns/100ps

module rv_core
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic      clk,
  input  logic      rst,
  output word_t     imem_addr,
  input  insn_u     imem_insn,
  output logic      trace_valid,
  output word_t     trace_pc,
  output insn_u     trace_insn,
  output logic      trace_we,
  output reg_addr_t trace_rd,
  output word_t     trace_data,
  output logic      halt
);

  // register file ports
  reg_addr_t rf_rs1;
  reg_addr_t rf_rs2;
  word_t     rf_rs1_data;
  word_t     rf_rs2_data;

  // decoded operation
  logic      d_valid;
  word_t     d_pc;
  insn_u     d_insn;
  alu_op_e   d_op;
  reg_addr_t d_rd;
  reg_addr_t d_rs1;
  reg_addr_t d_rs2;
  word_t     d_rs1_data;
  word_t     d_rs2_data;
  word_t     d_imm;
  logic      d_use_imm;
  logic      d_ecall;

  // writeback into the register file
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;

  fetch_decode #(
    .RESET_PC(RESET_PC)
  ) fetch_decode_inst (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_insn  (imem_insn),
    .rf_rs1     (rf_rs1),
    .rf_rs2     (rf_rs2),
    .rf_rs1_data(rf_rs1_data),
    .rf_rs2_data(rf_rs2_data),
    .d_valid    (d_valid),
    .d_pc       (d_pc),
    .d_insn     (d_insn),
    .d_op       (d_op),
    .d_rd       (d_rd),
    .d_rs1      (d_rs1),
    .d_rs2      (d_rs2),
    .d_rs1_data (d_rs1_data),
    .d_rs2_data (d_rs2_data),
    .d_imm      (d_imm),
    .d_use_imm  (d_use_imm),
    .d_ecall    (d_ecall)
  );

  reg_file reg_file_inst (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rf_rs1),
    .rs2     (rf_rs2),
    .rs1_data(rf_rs1_data),
    .rs2_data(rf_rs2_data),
    .we      (wb_we),
    .rd      (wb_rd),
    .rd_data (wb_data)
  );

  execute_writeback execute_writeback_inst (
    .clk        (clk),
    .rst        (rst),
    .d_valid    (d_valid),
    .d_pc       (d_pc),
    .d_insn     (d_insn),
    .d_op       (d_op),
    .d_rd       (d_rd),
    .d_rs1      (d_rs1),
    .d_rs2      (d_rs2),
    .d_rs1_data (d_rs1_data),
    .d_rs2_data (d_rs2_data),
    .d_imm      (d_imm),
    .d_use_imm  (d_use_imm),
    .d_ecall    (d_ecall),
    .wb_we      (wb_we),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .trace_valid(trace_valid),
    .trace_pc   (trace_pc),
    .trace_insn (trace_insn),
    .trace_we   (trace_we),
    .trace_rd   (trace_rd),
    .trace_data (trace_data),
    .halt       (halt)
  );

endmodule

// File: tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// program rom and the expected trace with one entry per retirement
int        seed;
insn_u     rom [prog_len];
word_t     model_regs [32];
logic      exp_we [prog_len];
reg_addr_t exp_rd [prog_len];
word_t     exp_data [prog_len];
logic      exp_halt [prog_len];

// registers limited to x0..x7 so hazards show up often
function automatic insn_u random_insn();
  insn_u       w;
  int unsigned kind;
  kind = $unsigned($random(seed)) % 20;
  w = insn_u'($random(seed));
  if (kind >= 18) begin
    // raw random word that is usually illegal
    return insn_u'($random(seed));
  end
  w.r_fields.rd  = {2'b00, w.r_fields.rd[2:0]};
  w.r_fields.rs1 = {2'b00, w.r_fields.rs1[2:0]};
  w.r_fields.rs2 = {2'b00, w.r_fields.rs2[2:0]};
  if (kind >= 16) begin
    w.r_fields.opcode = op_lui;
    return w;
  end
  w.r_fields.opcode = (kind < 8) ? op_reg_imm : op_reg_reg;
  // upper seven bits mostly zero or alt and sometimes left random
  case (w.r_fields.funct7[6:4])
    3'b111:          w.r_fields.funct7 = w.r_fields.funct7;
    3'b110, 3'b101:  w.r_fields.funct7 = funct7_alt;
    default:         w.r_fields.funct7 = 7'b0;
  endcase
  return w;
endfunction

task automatic build_program();
  for (int i = 0; i < prog_len - 1; i++) begin
    rom[i] = random_insn();
  end
  rom[prog_len - 1] = insn_u'(32'h0000_0073);
endtask

function automatic logic legal_alu(input insn_u w);
  logic shift;
  logic zero7;
  logic alt7;
  shift = w.r_fields.funct3 == f3_sll || w.r_fields.funct3 == f3_srl_sra;
  zero7 = w.r_fields.funct7 == 7'b0;
  alt7  = w.r_fields.funct7 == funct7_alt;
  if (w.r_fields.opcode == op_reg_reg) begin
    return zero7 || (alt7 && (w.r_fields.funct3 == f3_add_sub ||
                              w.r_fields.funct3 == f3_srl_sra));
  end
  return !shift || zero7 || (alt7 && w.r_fields.funct3 == f3_srl_sra);
endfunction

function automatic word_t alu_result(input logic [2:0] f3, input logic use_alt,
                                     input word_t a, input word_t b);
  case (f3)
    f3_add_sub: return use_alt ? a - b : a + b;
    f3_sll:     return a << b[4:0];
    f3_slt:     return {31'b0, $signed(a) < $signed(b)};
    f3_sltu:    return {31'b0, a < b};
    f3_xor:     return a ^ b;
    f3_srl_sra: return use_alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    f3_or:      return a | b;
    default:    return a & b;
  endcase
endfunction

// in-order execution of the whole program
task automatic run_model();
  insn_u w;
  word_t a;
  word_t b;
  word_t v;
  logic  ok;
  logic  is_rr;
  for (int r = 0; r < 32; r++) begin
    model_regs[r] = '0;
  end
  for (int i = 0; i < prog_len; i++) begin
    w     = rom[i];
    is_rr = w.r_fields.opcode == op_reg_reg;
    a     = model_regs[w.r_fields.rs1];
    b     = is_rr ? model_regs[w.r_fields.rs2] : {{20{w.i_fields.imm[11]}}, w.i_fields.imm};
    ok    = 1'b0;
    v     = '0;
    if (w.r_fields.opcode == op_lui) begin
      ok = 1'b1;
      v  = {w[31:12], 12'h000};
    end else if (is_rr || w.r_fields.opcode == op_reg_imm) begin
      ok = legal_alu(w);
      v  = alu_result(w.r_fields.funct3, w.r_fields.funct7 == funct7_alt &&
                      (is_rr || w.r_fields.funct3 == f3_srl_sra), a, b);
    end
    exp_we[i]   = ok && w.r_fields.rd != 5'd0;
    exp_rd[i]   = w.r_fields.rd;
    exp_data[i] = v;
    exp_halt[i] = w == 32'h0000_0073;
    if (exp_we[i]) begin
      model_regs[w.r_fields.rd] = v;
    end
  end
endtask

`endif

// File: tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core
  import rv_core_pkg::*;
;

  localparam word_t reset_pc       = 32'h0000_0100;
  localparam int    prog_len       = 200;
  localparam int    reset_cycles   = 10;
  localparam int    fill_cycles    = 3;
  localparam int    timeout_cycles = prog_len + reset_cycles + 20;

  logic      clk = 1'b0;
  logic      rst;
  word_t     imem_addr;
  insn_u     imem_insn;
  logic      trace_valid;
  word_t     trace_pc;
  insn_u     trace_insn;
  logic      trace_we;
  reg_addr_t trace_rd;
  word_t     trace_data;
  logic      halt;

  word_t     rom_idx;
  int        cycle_count = 0;

  `include "tb_model.svh"

  rv_core #(
    .RESET_PC(reset_pc)
  ) rv_core_inst (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_insn  (imem_insn),
    .trace_valid(trace_valid),
    .trace_pc   (trace_pc),
    .trace_insn (trace_insn),
    .trace_we   (trace_we),
    .trace_rd   (trace_rd),
    .trace_data (trace_data),
    .halt       (halt)
  );

  always #4 clk = ~clk;

  // combinational instruction port with nops past the end of the program
  always_comb begin
    rom_idx = (imem_addr - reset_pc) >> 2;
    if (rom_idx < word_t'(prog_len)) begin
      imem_insn = rom[rom_idx[7:0]];
    end else begin
      imem_insn = insn_u'(32'h0000_0013);
    end
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_insn(input string name, input insn_u got, input insn_u exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_idle_outputs();
    check_bit("trace_valid", trace_valid, 1'b0);
    check_bit("trace_we", trace_we, 1'b0);
    check_bit("halt", halt, 1'b0);
  endtask

  task automatic check_retirement(input int n);
    check_bit($sformatf("trace_valid[%0d]", n), trace_valid, 1'b1);
    check_word("imem_addr", imem_addr, reset_pc + word_t'(4 * (n + fill_cycles)));
    check_word($sformatf("trace_pc[%0d]", n), trace_pc, reset_pc + word_t'(4 * n));
    check_insn($sformatf("trace_insn[%0d]", n), trace_insn, rom[n]);
    check_bit($sformatf("trace_we[%0d]", n), trace_we, exp_we[n]);
    check_bit($sformatf("halt[%0d]", n), halt, exp_halt[n]);
    if (exp_we[n]) begin
      check_reg($sformatf("trace_rd[%0d]", n), trace_rd, exp_rd[n]);
      check_word($sformatf("trace_data[%0d]", n), trace_data, exp_data[n]);
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      fail_run($sformatf("timeout: no end of program after %0d cycles", timeout_cycles));
    end
  end

  initial begin
    rst  = 1'b1;
    seed = 32'h8f1f_4c98;
    build_program();
    run_model();
    for (int i = 0; i < reset_cycles; i++) begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst = 1'b0;
    // first fetch and then the pipeline fill
    for (int i = 0; i <= fill_cycles; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      check_word("imem_addr", imem_addr, reset_pc + word_t'(4 * i));
      if (i < fill_cycles) begin
        check_idle_outputs();
      end
    end
    if (trace_valid !== 1'b1) begin
      fail_run("trace_valid did not rise 3 cycles after the first fetch");
    end
    for (int n = 0; n < prog_len; n++) begin
      if (n > 0) begin
        @(negedge clk);
      end
      check_retirement(n);
    end
    // halt lasts one cycle only
    @(negedge clk);
    check_bit("halt after ecall", halt, 1'b0);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
rv_core_pkg.sv
fetch_decode.sv
reg_file.sv
execute_writeback.sv
rv_core.sv
tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) tb_model.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
